// File: sim.f
rtl/cpuPkg.sv
rtl/aluUnit.sv
rtl/registerFile.sv
rtl/controlSequencer.sv
rtl/dataPath.sv
rtl/programMemory.sv
rtl/cpuTop.sv
tb/cpuTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= cpuTb
FILELIST ?= sim.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tb/cpuTb.sv
`timescale 1ns/1ps
module cpuTb;
    localparam int MemAddrWidth = 6;
    localparam int RandomLen = 20;
    localparam int DirectedWords = 32;                   // Words in the five directed programs
    localparam int TotalWords = DirectedWords + 2 * (cpuPkg::RegCount + RandomLen + 1);
    localparam int WatchdogNs = 6 * TotalWords * 4 * 2 + 2000;

    logic                    clock;
    logic                    rstN;
    logic                    run;
    logic                    loadEn;
    logic [MemAddrWidth-1:0] loadAddr;
    logic [31:0]             loadData;
    logic [3:0]              dbgSel;
    logic                    halted;
    logic [MemAddrWidth-1:0] pc;
    logic [31:0]             dbgData;

    logic [31:0] prog[$];                                // Program under test
    logic [31:0] modelRegs [16];
    bit          modelValid [16];                        // Registers the model has written
    int          modelHaltAt;
    logic [31:0] lcgState;

    cpuTop #(.MemAddrWidth(MemAddrWidth)) UUT (
        .clock    (clock),
        .rstN     (rstN),
        .run      (run),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .dbgSel   (dbgSel),
        .halted   (halted),
        .pc       (pc),
        .dbgData  (dbgData)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        #(WatchdogNs);
        $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
        $display("** FAIL **");
        $fatal(1, "Watchdog expired");
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] encodeReg(logic [4:0] op, logic [3:0] ra, logic [3:0] rb,
                                              logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic logic [31:0] encodeImm(logic [4:0] op, logic [3:0] ra, logic [3:0] rb,
                                              logic [18:0] c);
        return {op, ra, rb, c};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, expected);
            $display("** FAIL **");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Walks the program up to the first HALT or unknown opcode
    task automatic runModel();
        logic [4:0]  op;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [31:0] yVal;
        logic [31:0] cVal;
        int          i;
        foreach (modelValid[r]) modelValid[r] = 1'b0;
        modelHaltAt = -1;
        i = 0;
        while (modelHaltAt < 0 && i < prog.size()) begin
            op = prog[i][31:27];
            ra = prog[i][26:23];
            rb = prog[i][22:19];
            rc = prog[i][18:15];
            yVal = (rb == 4'd0) ? 32'd0 : modelRegs[rb];   // Base read of R0 is zero
            cVal = {{13{prog[i][18]}}, prog[i][18:0]};
            if (op == cpuPkg::opLdi) begin
                modelRegs[ra] = yVal + cVal;
            end else if (op == cpuPkg::opAdd) begin
                modelRegs[ra] = yVal + modelRegs[rc];
            end else if (op == cpuPkg::opSub) begin
                modelRegs[ra] = yVal - modelRegs[rc];
            end else if (op == cpuPkg::opAnd) begin
                modelRegs[ra] = yVal & modelRegs[rc];
            end else if (op == cpuPkg::opOr) begin
                modelRegs[ra] = yVal | modelRegs[rc];
            end else begin
                modelHaltAt = i;
            end
            if (modelHaltAt < 0) modelValid[ra] = 1'b1;
            i++;
        end
    endtask

    task automatic resetDut();
        @(posedge clock);
        rstN <= 1'b0;
        run <= 1'b0;
        loadEn <= 1'b0;
        repeat (5) @(posedge clock);
        rstN <= 1'b1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clock);
            loadEn <= 1'b1;
            loadAddr <= MemAddrWidth'(i);
            loadData <= prog[i];
        end
        @(posedge clock);
        loadEn <= 1'b0;
    endtask

    task automatic checkRegisters();
        for (int r = 0; r < 16; r++) begin
            if (modelValid[r]) begin
                @(posedge clock);
                dbgSel <= r[3:0];
                @(negedge clock);
                checkValue($sformatf("R%0d", r), dbgData, modelRegs[r]);
            end
        end
    endtask

    task automatic runProgram();
        int cycles;
        int limit;
        resetDut();
        loadProgram();
        runModel();
        @(posedge clock);
        run <= 1'b1;
        @(posedge clock);                                   // Edge that opens cycle 1
        cycles = 0;
        limit = 6 * prog.size() + 20;
        while (halted !== 1'b1 && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("Timeout: halted never rose within %0d cycles", limit);
            $display("** FAIL **");
            $fatal(1, "No halt");
        end
        checkValue("haltCycle", cycles, 6 * modelHaltAt + 5);   // Visible one cycle after T3
        checkValue("pc", 32'(pc), (modelHaltAt + 1) % (2 ** MemAddrWidth));
        @(posedge clock);
        run <= 1'b0;
        checkRegisters();
    endtask

    task automatic testLdiConstants();
        prog.delete();
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd1, 4'd0, 19'd5));
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd2, 4'd0, 19'h7fff9));   // -7
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd3, 4'd0, 19'h3ffff));   // Largest positive
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd4, 4'd0, 19'h40000));   // Most negative
        prog.push_back(encodeReg(cpuPkg::opHalt, 4'd0, 4'd0, 4'd0));
        runProgram();
    endtask

    task automatic testLdiBase();
        prog.delete();
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd1, 4'd0, 19'd100));
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd2, 4'd1, 19'h7ffff));
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd3, 4'd2, 19'h40000));
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd1, 4'd1, 19'd1));       // Source is the target
        prog.push_back(encodeReg(cpuPkg::opHalt, 4'd0, 4'd0, 4'd0));
        runProgram();
    endtask

    task automatic testAddSub();
        prog.delete();
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd1, 4'd0, 19'h3ffff));
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd2, 4'd0, 19'h7ffff));
        prog.push_back(encodeReg(cpuPkg::opAdd, 4'd3, 4'd1, 4'd2));
        prog.push_back(encodeReg(cpuPkg::opSub, 4'd4, 4'd0, 4'd1));
        prog.push_back(encodeReg(cpuPkg::opAdd, 4'd5, 4'd2, 4'd2));        // Wraps past 2**32
        prog.push_back(encodeReg(cpuPkg::opSub, 4'd6, 4'd1, 4'd2));
        prog.push_back(encodeReg(cpuPkg::opSub, 4'd7, 4'd4, 4'd1));
        prog.push_back(encodeReg(cpuPkg::opHalt, 4'd0, 4'd0, 4'd0));
        runProgram();
    endtask

    task automatic testAndOr();
        prog.delete();
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd0, 4'd0, 19'h01234));   // Stored value in R0
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd1, 4'd0, 19'h7ffff));
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd2, 4'd0, 19'h0f0f0));
        prog.push_back(encodeReg(cpuPkg::opAnd, 4'd3, 4'd1, 4'd0));        // R0 under Grc
        prog.push_back(encodeReg(cpuPkg::opOr, 4'd4, 4'd2, 4'd0));
        prog.push_back(encodeReg(cpuPkg::opAnd, 4'd5, 4'd0, 4'd1));        // R0 under BAout
        prog.push_back(encodeReg(cpuPkg::opOr, 4'd6, 4'd0, 4'd2));
        prog.push_back(encodeReg(cpuPkg::opHalt, 4'd0, 4'd0, 4'd0));
        runProgram();
    endtask

    task automatic testHalt();
        prog.delete();
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd1, 4'd0, 19'd11));
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd5, 4'd0, 19'd22));
        prog.push_back(encodeReg(cpuPkg::opHalt, 4'd0, 4'd0, 4'd0));
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd5, 4'd0, 19'd33));      // Never executed
        prog.push_back(encodeImm(cpuPkg::opLdi, 4'd1, 4'd1, 19'd1));
        prog.push_back(encodeReg(cpuPkg::opHalt, 4'd0, 4'd0, 4'd0));
        runProgram();
        @(posedge clock);
        run <= 1'b1;                                        // Stopped CPU ignores run
        repeat (12) @(negedge clock);
        checkValue("halted", 32'(halted), 32'd1);
        checkValue("pc", 32'(pc), 32'd3);
        checkRegisters();
        @(posedge clock);
        run <= 1'b0;
    endtask

    task automatic testRandom();
        logic [31:0] rnd;
        logic [31:0] fields;
        logic [4:0]  op;
        for (int p = 0; p < 2; p++) begin
            prog.delete();
            for (int r = 0; r < 16; r++) begin
                rnd = lcgNext();
                prog.push_back(encodeImm(cpuPkg::opLdi, r[3:0], 4'd0, rnd[30:12]));
            end
            for (int k = 0; k < RandomLen; k++) begin
                rnd = lcgNext();
                fields = lcgNext();
                case ((rnd >> 24) % 5)
                    0: op = cpuPkg::opLdi;
                    1: op = cpuPkg::opAdd;
                    2: op = cpuPkg::opSub;
                    3: op = cpuPkg::opAnd;
                    default: op = cpuPkg::opOr;
                endcase
                if (op == cpuPkg::opLdi) begin
                    prog.push_back(encodeImm(op, fields[31:28], fields[27:24], fields[18:0]));
                end else begin
                    prog.push_back(encodeReg(op, fields[31:28], fields[27:24], fields[23:20]));
                end
            end
            prog.push_back(encodeReg(cpuPkg::opHalt, 4'd0, 4'd0, 4'd0));
            runProgram();
        end
    endtask

    initial begin
        rstN = 1'b0;
        run = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        dbgSel = '0;
        lcgState = 32'haa60;
        testLdiConstants();
        testLdiBase();
        testAddSub();
        testAndOr();
        testHalt();
        testRandom();
        $display("** PASS **");
        $finish;
    end

endmodule

// File: rtl/cpuTop.sv
`timescale 1ns/1ps
module cpuTop #(
    parameter int MemAddrWidth = 6
) (
    input  logic                               clock,
    input  logic                               rstN,
    input  logic                               run,
    input  logic                               loadEn,
    input  logic [MemAddrWidth-1:0]            loadAddr,
    input  logic [cpuPkg::DataWidth-1:0]       loadData,
    input  logic [cpuPkg::RegSelWidth-1:0]     dbgSel,
    output logic                               halted,
    output logic [MemAddrWidth-1:0]            pc,
    output logic [cpuPkg::DataWidth-1:0]       dbgData
);
    logic                         pcOut;
    logic                         marIn;
    logic                         incPc;
    logic                         zlowIn;
    logic                         zlowOut;
    logic                         pcIn;
    logic                         read;
    logic                         mdrIn;
    logic                         mdrOut;
    logic                         irIn;
    logic                         grA;
    logic                         grB;
    logic                         grC;
    logic                         baOut;
    logic                         rOut;
    logic                         yIn;
    logic                         rIn;
    logic                         cSignOut;
    cpuPkg::aluOpT                aluOp;
    cpuPkg::instrWordT            ir;
    logic [MemAddrWidth-1:0]      mar;
    logic [cpuPkg::DataWidth-1:0] memData;

    // Strobes fan out from the sequencer, memory sits between MAR and MDR
    controlSequencer sequencerInst (.*);

    dataPath #(
        .MemAddrWidth (MemAddrWidth)
    ) dataPathInst (.*);

    programMemory #(
        .MemAddrWidth (MemAddrWidth)
    ) memoryInst (.*);

endmodule

// File: rtl/programMemory.sv
`timescale 1ns/1ps
module programMemory #(
    parameter int MemAddrWidth = 6
) (
    input  logic                         clock,
    input  logic                         loadEn,
    input  logic [MemAddrWidth-1:0]      loadAddr,
    input  logic [cpuPkg::DataWidth-1:0] loadData,
    input  logic [MemAddrWidth-1:0]      mar,
    input  logic                         read,
    output logic [cpuPkg::DataWidth-1:0] memData
);
    logic [cpuPkg::DataWidth-1:0] mem [2**MemAddrWidth];

    always_ff @(posedge clock) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;       // Program load from outside
        end
    end

    assign memData = read ? mem[mar] : '0;   // Combinational read at MAR

    // Loading is only legal while the CPU is stopped
    noLoadWhileRun: assert property (@(posedge clock) !(loadEn && read));

endmodule

// File: rtl/dataPath.sv
`timescale 1ns/1ps
module dataPath #(
    parameter int MemAddrWidth = 6
) (
    input  logic                               clock,
    input  logic                               rstN,
    input  logic                               pcOut,
    input  logic                               marIn,
    input  logic                               incPc,
    input  logic                               zlowIn,
    input  logic                               zlowOut,
    input  logic                               pcIn,
    input  logic                               read,
    input  logic                               mdrIn,
    input  logic                               mdrOut,
    input  logic                               irIn,
    input  logic                               grA,
    input  logic                               grB,
    input  logic                               grC,
    input  logic                               baOut,
    input  logic                               rOut,
    input  logic                               yIn,
    input  logic                               rIn,
    input  logic                               cSignOut,
    input  cpuPkg::aluOpT                      aluOp,
    input  logic [cpuPkg::DataWidth-1:0]       memData,
    input  logic [cpuPkg::RegSelWidth-1:0]     dbgSel,
    output cpuPkg::instrWordT                  ir,
    output logic [MemAddrWidth-1:0]            mar,
    output logic [MemAddrWidth-1:0]            pc,
    output logic [cpuPkg::DataWidth-1:0]       dbgData
);
    logic [cpuPkg::DataWidth-1:0] bus;
    logic [cpuPkg::DataWidth-1:0] pcReg;
    logic [MemAddrWidth-1:0]      marReg;
    logic [cpuPkg::DataWidth-1:0] mdrReg;
    cpuPkg::instrWordT            irReg;
    logic [cpuPkg::DataWidth-1:0] yReg;
    logic [cpuPkg::DataWidth-1:0] zReg;
    logic [cpuPkg::DataWidth-1:0] regOut;
    logic [cpuPkg::DataWidth-1:0] cSign;
    logic [cpuPkg::DataWidth-1:0] aluResult;
    cpuPkg::aluOpT                aluSel;

    assign cSign = {
        {(cpuPkg::DataWidth - cpuPkg::ConstWidth){irReg.iFormat.c[cpuPkg::ConstWidth-1]}},
        irReg.iFormat.c
    };

    // Bus reads zero when no strobe drives it
    always_comb begin
        bus = '0;
        if (pcOut) begin
            bus = pcReg;
        end else if (zlowOut) begin
            bus = zReg;
        end else if (mdrOut) begin
            bus = mdrReg;
        end else if (baOut || rOut) begin
            bus = regOut;
        end else if (cSignOut) begin
            bus = cSign;
        end
    end

    assign aluSel = incPc ? cpuPkg::aluInc : aluOp;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pcReg <= '0;
            marReg <= '0;
            irReg <= '0;
            yReg <= '0;
            zReg <= '0;
        end else begin
            if (pcIn) pcReg <= bus;
            if (marIn) marReg <= bus[MemAddrWidth-1:0];
            if (irIn) irReg <= bus;
            if (yIn) yReg <= bus;
            if (zlowIn) zReg <= aluResult;
        end
    end

    always_ff @(posedge clock) begin
        if (mdrIn) begin
            mdrReg <= read ? memData : bus;   // Memory side during fetch
        end
    end

    registerFile regFileInst (
        .clock   (clock),
        .grA     (grA),
        .grB     (grB),
        .grC     (grC),
        .baOut   (baOut),
        .rIn     (rIn),
        .ir      (irReg),
        .busIn   (bus),
        .dbgSel  (dbgSel),
        .regOut  (regOut),
        .dbgData (dbgData)
    );

    aluUnit aluInst (
        .aluOp  (aluSel),
        .yVal   (yReg),
        .busIn  (bus),
        .result (aluResult)
    );

    assign ir = irReg;
    assign mar = marReg;
    assign pc = pcReg[MemAddrWidth-1:0];

endmodule

// File: rtl/controlSequencer.sv
`timescale 1ns/1ps
module controlSequencer (
    input  logic              clock,
    input  logic              rstN,
    input  logic              run,
    input  cpuPkg::instrWordT ir,
    output logic              pcOut,
    output logic              marIn,
    output logic              incPc,
    output logic              zlowIn,
    output logic              zlowOut,
    output logic              pcIn,
    output logic              read,
    output logic              mdrIn,
    output logic              mdrOut,
    output logic              irIn,
    output logic              grA,
    output logic              grB,
    output logic              grC,
    output logic              baOut,
    output logic              rOut,
    output logic              yIn,
    output logic              rIn,
    output logic              cSignOut,
    output cpuPkg::aluOpT     aluOp,
    output logic              halted
);
    localparam logic [2:0] T0 = 3'd0;
    localparam logic [2:0] T1 = 3'd1;
    localparam logic [2:0] T2 = 3'd2;
    localparam logic [2:0] T3 = 3'd3;
    localparam logic [2:0] T4 = 3'd4;
    localparam logic [2:0] T5 = 3'd5;

    localparam int StrobeCount = 18;
    localparam int pcOutBit = 0;
    localparam int marInBit = 1;
    localparam int incPcBit = 2;
    localparam int zlowInBit = 3;
    localparam int zlowOutBit = 4;
    localparam int pcInBit = 5;
    localparam int readBit = 6;
    localparam int mdrInBit = 7;
    localparam int mdrOutBit = 8;
    localparam int irInBit = 9;
    localparam int grABit = 10;
    localparam int grBBit = 11;
    localparam int grCBit = 12;
    localparam int baOutBit = 13;
    localparam int rOutBit = 14;
    localparam int yInBit = 15;
    localparam int rInBit = 16;
    localparam int cSignOutBit = 17;

    logic [2:0]             tState;      // Step whose strobes are on the outputs
    logic                   active;      // Low while idle, paused or halted
    logic [2:0]             issueState;
    logic                   stopNow;
    logic                   issue;
    logic                   isLdi;
    logic                   isAluOp;
    cpuPkg::aluOpT          opAlu;
    cpuPkg::aluOpT          aluD;
    logic [StrobeCount-1:0] strobeD;
    logic [StrobeCount-1:0] strobeQ;

    always_comb begin
        isAluOp = 1'b1;
        opAlu = cpuPkg::aluAdd;
        case (ir.rFormat.opcode)
            cpuPkg::opAdd: opAlu = cpuPkg::aluAdd;
            cpuPkg::opSub: opAlu = cpuPkg::aluSub;
            cpuPkg::opAnd: opAlu = cpuPkg::aluAnd;
            cpuPkg::opOr:  opAlu = cpuPkg::aluOr;
            default:       isAluOp = 1'b0;
        endcase
    end

    assign isLdi = (ir.rFormat.opcode == cpuPkg::opLdi);

    // IR is valid from T3 on, so HALT is caught while T3 is showing
    assign issueState = (active && tState != T5) ? tState + 3'd1 : T0;
    assign stopNow = active && (tState == T3) && !isAluOp && !isLdi;
    assign issue = !halted && !stopNow && (issueState != T0 || run);

    always_comb begin
        strobeD = '0;
        aluD = cpuPkg::aluAdd;
        case (issueState)
            T0: begin
                strobeD[pcOutBit] = 1'b1;
                strobeD[marInBit] = 1'b1;
                strobeD[incPcBit] = 1'b1;
                strobeD[zlowInBit] = 1'b1;
            end
            T1: begin
                strobeD[zlowOutBit] = 1'b1;
                strobeD[pcInBit] = 1'b1;
                strobeD[readBit] = 1'b1;
                strobeD[mdrInBit] = 1'b1;
            end
            T2: begin
                strobeD[mdrOutBit] = 1'b1;
                strobeD[irInBit] = 1'b1;
            end
            T3: begin
                strobeD[grBBit] = 1'b1;
                strobeD[baOutBit] = 1'b1;
                strobeD[yInBit] = 1'b1;
            end
            T4: begin
                strobeD[zlowInBit] = 1'b1;
                if (isAluOp) begin
                    strobeD[grCBit] = 1'b1;
                    strobeD[rOutBit] = 1'b1;
                    aluD = opAlu;
                end else begin
                    strobeD[cSignOutBit] = 1'b1;   // LDI adds C to Y
                end
            end
            T5: begin
                strobeD[zlowOutBit] = 1'b1;
                strobeD[grABit] = 1'b1;
                strobeD[rInBit] = 1'b1;
            end
            default: strobeD = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            tState <= T0;
            active <= 1'b0;
            halted <= 1'b0;
            strobeQ <= '0;
            aluOp <= cpuPkg::aluAdd;
        end else begin
            active <= issue;
            strobeQ <= issue ? strobeD : '0;
            aluOp <= aluD;
            if (stopNow) begin
                halted <= 1'b1;                   // Held in T3 until reset
            end
            if (issue) begin
                tState <= issueState;
            end else if (!stopNow && !halted) begin
                tState <= T0;                     // Paused waiting for run
            end
        end
    end

    assign pcOut = strobeQ[pcOutBit];
    assign marIn = strobeQ[marInBit];
    assign incPc = strobeQ[incPcBit];
    assign zlowIn = strobeQ[zlowInBit];
    assign zlowOut = strobeQ[zlowOutBit];
    assign pcIn = strobeQ[pcInBit];
    assign read = strobeQ[readBit];
    assign mdrIn = strobeQ[mdrInBit];
    assign mdrOut = strobeQ[mdrOutBit];
    assign irIn = strobeQ[irInBit];
    assign grA = strobeQ[grABit];
    assign grB = strobeQ[grBBit];
    assign grC = strobeQ[grCBit];
    assign baOut = strobeQ[baOutBit];
    assign rOut = strobeQ[rOutBit];
    assign yIn = strobeQ[yInBit];
    assign rIn = strobeQ[rInBit];
    assign cSignOut = strobeQ[cSignOutBit];

    busOneDriver: assert property (@(posedge clock) disable iff (!rstN)
        $onehot0({pcOut, zlowOut, mdrOut, baOut, rOut, cSignOut}));

    haltSticky: assert property (@(posedge clock) disable iff (!rstN)
        halted |=> halted);

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/1ps
module registerFile (
    input  logic                               clock,
    input  logic                               grA,
    input  logic                               grB,
    input  logic                               grC,
    input  logic                               baOut,
    input  logic                               rIn,
    input  cpuPkg::instrWordT                  ir,
    input  logic [cpuPkg::DataWidth-1:0]       busIn,
    input  logic [cpuPkg::RegSelWidth-1:0]     dbgSel,
    output logic [cpuPkg::DataWidth-1:0]       regOut,
    output logic [cpuPkg::DataWidth-1:0]       dbgData
);
    logic [cpuPkg::DataWidth-1:0]   regs [cpuPkg::RegCount];
    logic [cpuPkg::RegSelWidth-1:0] sel;

    // Field select from IR, Gra wins over Grb over Grc
    always_comb begin
        if (grA) begin
            sel = ir.rFormat.ra;
        end else if (grB) begin
            sel = ir.rFormat.rb;
        end else begin
            sel = ir.rFormat.rc;
        end
    end

    always_ff @(posedge clock) begin
        if (rIn) begin
            regs[sel] <= busIn;
        end
    end

    assign regOut = (baOut && sel == '0) ? '0 : regs[sel];   // Base rule for R0
    assign dbgData = regs[dbgSel];

    // A register port in use needs exactly one field select
    oneSelect: assert property (@(posedge clock)
        (rIn || baOut) |-> $onehot({grA, grB, grC}));

endmodule

// File: rtl/aluUnit.sv
`timescale 1ns/1ps
module aluUnit (
    input  cpuPkg::aluOpT                aluOp,
    input  logic [cpuPkg::DataWidth-1:0] yVal,
    input  logic [cpuPkg::DataWidth-1:0] busIn,
    output logic [cpuPkg::DataWidth-1:0] result
);
    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd: begin
                result = yVal + busIn;       // Wraps at 32 bits
            end
            cpuPkg::aluSub: begin
                result = yVal - busIn;
            end
            cpuPkg::aluAnd: begin
                result = yVal & busIn;
            end
            cpuPkg::aluOr: begin
                result = yVal | busIn;
            end
            cpuPkg::aluInc: begin
                result = busIn + 1'b1;       // PC step, Y not involved
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: rtl/cpuPkg.sv
package cpuPkg;

    localparam int DataWidth = 32;
    localparam int RegCount = 16;
    localparam int RegSelWidth = 4;
    localparam int OpcodeWidth = 5;
    localparam int ConstWidth = 19;

    // Anything outside this list decodes as HALT
    typedef enum logic [OpcodeWidth-1:0] {
        opLdi  = 5'd1,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opHalt = 5'd27
    } opcodeT;

    typedef union packed {
        struct packed {
            opcodeT                 opcode;
            logic [RegSelWidth-1:0] ra;      // Destination
            logic [RegSelWidth-1:0] rb;      // First source, goes to Y
            logic [RegSelWidth-1:0] rc;      // Second source
            logic [14:0]            unused;
        } rFormat;
        struct packed {
            opcodeT                 opcode;
            logic [RegSelWidth-1:0] ra;
            logic [RegSelWidth-1:0] rb;      // Base register, R0 reads as zero
            logic [ConstWidth-1:0]  c;       // Signed constant
        } iFormat;
    } instrWordT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluInc = 3'd4
    } aluOpT;

endpackage
